//--- verilog/blueprint_pkg.sv
// --------------------
// Raster sizes, sprite table layout and shared types
// of the sprite video path
// --------------------
package blueprint_pkg;

	// --------------------
	// Raster geometry, counted in pixels and lines
	localparam int h_total  = 320;
	localparam int h_active = 256;
	localparam int v_total  = 264;
	// First and last+1 visible line
	localparam int v_first  = 16;
	localparam int v_last   = 240;

	// Sync start positions before centering, and sync widths
	localparam int hs_base  = 280;
	localparam int vs_base  = 248;
	localparam int hs_width = 32;
	localparam int vs_width = 4;

	// --------------------
	// Sprite table
	localparam int sprite_count    = 64;
	localparam int sprite_x_offset = 2;
	// Screen y of a sprite is 240 minus byte 0, drawn one line higher
	localparam int spr_y_base      = 239;

	typedef logic [8:0] cnt_t;

	// Four bytes per sprite: y, code, flags, x
	typedef struct packed {
		logic [5:0] index;
		logic [1:0] num;
	} spr_addr_t;

	// One 8 pixel row per address, 16 rows per code
	typedef struct packed {
		logic [7:0] code;
		logic [3:0] row;
	} gfx_addr_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] b;
		logic [7:0] g;
	} gfx_row_t;

	// Red in bit 0, all zero is transparent
	typedef struct packed {
		logic g;
		logic b;
		logic r;
	} spr_pix_t;

	typedef logic [4:0] colour_t;

	localparam colour_t full_level = 5'd31;

endpackage

//--- verilog/video_if.sv
// --------------------
// Raster bus and sprite pixel write bus
// --------------------

// Counters and blanking, all stepping on the pixel strobe
interface raster_if;
	logic                cen;
	blueprint_pkg::cnt_t h_cnt;
	blueprint_pkg::cnt_t v_cnt;
	logic                hblank;
	logic                vblank;
	// One clock wide, on the strobe that wraps h_cnt to 0
	logic                line_start;

	modport source (output cen, h_cnt, v_cnt, hblank, vblank, line_start);
	modport sink (input cen, h_cnt, v_cnt, hblank, vblank, line_start);
endinterface

// Writes into the back line buffer
interface sprite_wr_if;
	logic                    wr;
	logic [7:0]              x;
	blueprint_pkg::spr_pix_t pix;
	// Write zero instead of pix
	logic                    clear;

	modport source (output wr, x, pix, clear);
	modport sink (input wr, x, pix, clear);
endinterface

//--- verilog/pixel_cen.sv
// --------------------
// Fractional clock enable for the pixel strobe
// --------------------
module pixel_cen #(
	parameter int cen_num = 89,
	parameter int cen_den = 875
) (
	input  logic clk_49m,
	input  logic reset,
	output logic cen_o
);
	localparam int acc_w = $clog2(cen_num + cen_den);

	logic [acc_w-1:0] acc;
	logic [acc_w-1:0] sum;

	assign sum = acc + acc_w'(cen_num);

	// Average rate is clk times num over den
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			acc   <= '0;
			cen_o <= 1'b0;
		end else if (sum >= acc_w'(cen_den)) begin
			acc   <= sum - acc_w'(cen_den);
			cen_o <= 1'b1;
		end else begin
			acc   <= sum;
			cen_o <= 1'b0;
		end
	end
endmodule

//--- verilog/video_timing.sv
// --------------------
// Raster counter with blanking, line start and centred syncs
// --------------------
module video_timing (
	input  logic       clk_49m,
	input  logic       reset,
	input  logic       cen_i,
	input  logic [3:0] h_center_i,
	input  logic [3:0] v_center_i,
	raster_if.source   raster,
	output logic       hsync_o,
	output logic       vsync_o,
	output logic       csync_o
);
	localparam blueprint_pkg::cnt_t h_len  = blueprint_pkg::cnt_t'(blueprint_pkg::h_total);
	localparam blueprint_pkg::cnt_t v_len  = blueprint_pkg::cnt_t'(blueprint_pkg::v_total);
	localparam blueprint_pkg::cnt_t h_last = blueprint_pkg::cnt_t'(blueprint_pkg::h_total - 1);
	localparam blueprint_pkg::cnt_t v_last = blueprint_pkg::cnt_t'(blueprint_pkg::v_total - 1);

	blueprint_pkg::cnt_t h_cnt;
	blueprint_pkg::cnt_t v_cnt;
	blueprint_pkg::cnt_t hs_start;
	blueprint_pkg::cnt_t hs_end;
	blueprint_pkg::cnt_t vs_start;
	blueprint_pkg::cnt_t vs_end;

	// --------------------
	// Counters
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (cen_i) begin
			if (h_cnt == h_last) begin
				h_cnt <= '0;
				v_cnt <= (v_cnt == v_last) ? '0 : v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	assign raster.cen        = cen_i;
	assign raster.h_cnt      = h_cnt;
	assign raster.v_cnt      = v_cnt;
	assign raster.hblank     = h_cnt >= blueprint_pkg::h_active;
	assign raster.vblank     = (v_cnt < blueprint_pkg::v_first) ||
		(v_cnt >= blueprint_pkg::v_last);
	assign raster.line_start = cen_i && (h_cnt == h_last);

	// --------------------
	// Syncs, shifted by the centering offsets
	assign hs_start = blueprint_pkg::cnt_t'(blueprint_pkg::hs_base) + {5'd0, h_center_i};
	assign hs_end   = hs_start + blueprint_pkg::cnt_t'(blueprint_pkg::hs_width);
	assign vs_start = blueprint_pkg::cnt_t'(blueprint_pkg::vs_base) + {5'd0, v_center_i};
	assign vs_end   = vs_start + blueprint_pkg::cnt_t'(blueprint_pkg::vs_width);

	// A pulse running past the end of the count carries on from 0
	assign hsync_o = (h_cnt >= hs_start && h_cnt < hs_end) ||
		(hs_end > h_len && h_cnt < hs_end - h_len);
	assign vsync_o = (v_cnt >= vs_start && v_cnt < vs_end) ||
		(vs_end > v_len && v_cnt < vs_end - v_len);
	assign csync_o = ~(hsync_o ^ vsync_o);
endmodule

//--- verilog/sync_ram.sv
// --------------------
// Single clock RAM with registered read
// --------------------
module sync_ram #(
	parameter type payload_t = logic [7:0],
	parameter int  addr_w    = 8
) (
	input  logic              clk_49m,
	input  logic              we_i,
	input  logic [addr_w-1:0] waddr_i,
	input  payload_t          wdata_i,
	input  logic [addr_w-1:0] raddr_i,
	output payload_t          rdata_o
);
	payload_t mem [2**addr_w];

	always_ff @(posedge clk_49m) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// Data shows one clock after the address
	always_ff @(posedge clk_49m) begin
		rdata_o <= mem[raddr_i];
	end
endmodule

//--- verilog/sprite_scanner.sv
// --------------------
// Per line sprite scanner, run in HBlank
// Clears the back buffer, then draws every sprite hit on the next line
// --------------------
module sprite_scanner (
	input  logic                     clk_49m,
	input  logic                     reset,
	raster_if.sink                   raster,
	output blueprint_pkg::spr_addr_t spr_raddr_o,
	input  byte                      spr_rdata_i,
	output blueprint_pkg::gfx_addr_t gfx_raddr_o,
	input  blueprint_pkg::gfx_row_t  gfx_rdata_i,
	sprite_wr_if.source              wr
);
	localparam blueprint_pkg::cnt_t start_h = blueprint_pkg::cnt_t'(blueprint_pkg::h_active - 1);
	localparam blueprint_pkg::cnt_t y_adj   = blueprint_pkg::cnt_t'(blueprint_pkg::v_first - 1);
	localparam blueprint_pkg::cnt_t y_base  = blueprint_pkg::cnt_t'(blueprint_pkg::spr_y_base);
	localparam logic [5:0] last_idx = 6'(blueprint_pkg::sprite_count - 1);

	typedef enum logic [3:0] {
		s_idle,
		s_clear,
		s_seed,
		s_byte2,
		s_flag,
		s_byte1,
		s_byte3,
		s_gfx,
		s_pix
	} scan_state_t;

	scan_state_t             state;
	logic [7:0]              clr_x;
	logic [5:0]              idx;
	blueprint_pkg::cnt_t     y_line;
	blueprint_pkg::cnt_t     line_in;
	logic                    hit;
	logic                    prev_flipy;
	logic [3:0]              row;
	logic                    flip_x;
	logic [7:0]              x_base;
	logic [2:0]              pix_k;
	logic [2:0]              bit_sel;
	blueprint_pkg::spr_pix_t pix;

	// Row of the sprite on the target line, from byte 0
	assign line_in = y_line - y_base + {1'b0, spr_rdata_i};
	assign hit     = line_in[8:4] == 5'd0;

	// Flip X reads the planes from bit 0 upwards
	assign bit_sel = flip_x ? pix_k : 3'd7 - pix_k;
	assign pix.r   = gfx_rdata_i.r[bit_sel];
	assign pix.b   = gfx_rdata_i.b[bit_sel];
	assign pix.g   = gfx_rdata_i.g[bit_sel];

	// --------------------
	// Sprite RAM address, decoded from the state
	always_comb begin
		case (state)
			// Byte 2 of the last sprite seeds the flip Y chain
			s_clear: spr_raddr_o = '{index: last_idx, num: 2'd2};
			s_seed:  spr_raddr_o = '{index: idx, num: 2'd0};
			s_byte2: spr_raddr_o = '{index: idx, num: 2'd2};
			s_byte1: spr_raddr_o = '{index: idx, num: 2'd1};
			s_byte3: spr_raddr_o = '{index: idx, num: 2'd3};
			// Byte 0 of the next sprite
			default: spr_raddr_o = '{index: idx + 1'b1, num: 2'd0};
		endcase
	end

	// Line buffer writes, clear pass first, then opaque pixels only
	always_comb begin
		wr.wr    = 1'b0;
		wr.clear = 1'b0;
		wr.x     = clr_x;
		wr.pix   = pix;
		if (state == s_clear) begin
			wr.wr    = 1'b1;
			wr.clear = 1'b1;
		end else if (state == s_pix) begin
			wr.wr = pix != '0;
			wr.x  = x_base + {5'd0, pix_k} + 8'(blueprint_pkg::sprite_x_offset);
		end
	end

	// --------------------
	// Scan FSM
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			state <= s_idle;
			clr_x <= '0;
			idx   <= '0;
			pix_k <= '0;
		end else begin
			case (state)
				s_idle: begin
					// Starts as h_cnt steps to 256
					if (raster.cen && raster.h_cnt == start_h) begin
						// Screen row of the line after this one
						y_line <= raster.v_cnt - y_adj;
						clr_x  <= '0;
						idx    <= '0;
						state  <= s_clear;
					end
				end
				s_clear: begin
					clr_x <= clr_x + 1'b1;
					if (clr_x == 8'd255) begin
						state <= s_seed;
					end
				end
				s_seed: begin
					prev_flipy <= spr_rdata_i[7];
					state      <= s_byte2;
				end
				s_byte2: begin
					// Flip Y comes from the sprite before this one
					row   <= prev_flipy ? 4'd15 - line_in[3:0] : line_in[3:0];
					state <= hit ? s_byte1 : s_flag;
				end
				s_flag: begin
					// Miss, keep only the flip Y bit for the next sprite
					prev_flipy <= spr_rdata_i[7];
					idx        <= idx + 1'b1;
					state      <= (idx == last_idx) ? s_idle : s_byte2;
				end
				s_byte1: begin
					flip_x     <= spr_rdata_i[6];
					prev_flipy <= spr_rdata_i[7];
					state      <= s_byte3;
				end
				s_byte3: begin
					gfx_raddr_o <= '{code: spr_rdata_i, row: row};
					state       <= s_gfx;
				end
				s_gfx: begin
					x_base <= spr_rdata_i;
					pix_k  <= '0;
					state  <= s_pix;
				end
				s_pix: begin
					// Graphics row stays valid while the address holds
					pix_k <= pix_k + 1'b1;
					if (pix_k == 3'd7) begin
						idx   <= idx + 1'b1;
						state <= (idx == last_idx) ? s_idle : s_byte2;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end
endmodule

//--- verilog/line_buffer.sv
// --------------------
// Double sprite line buffer, swapped at each line start
// --------------------
module line_buffer (
	input  logic                    clk_49m,
	input  logic                    reset,
	raster_if.sink                  raster,
	sprite_wr_if.sink               wr,
	output blueprint_pkg::spr_pix_t pix_o
);
	localparam int depth = blueprint_pkg::h_active;

	blueprint_pkg::spr_pix_t buf0 [depth];
	blueprint_pkg::spr_pix_t buf1 [depth];
	// High when buf1 is on display
	logic                    front_sel;
	blueprint_pkg::spr_pix_t wdata;
	logic [7:0]              rd_x;

	assign wdata = wr.clear ? '0 : wr.pix;
	assign rd_x  = raster.h_cnt[7:0];

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			front_sel <= 1'b0;
		end else if (raster.line_start) begin
			front_sel <= ~front_sel;
		end
	end

	// Writes only reach the buffer off display
	always_ff @(posedge clk_49m) begin
		if (wr.wr) begin
			if (front_sel) begin
				buf0[wr.x] <= wdata;
			end else begin
				buf1[wr.x] <= wdata;
			end
		end
	end

	assign pix_o = front_sel ? buf1[rd_x] : buf0[rd_x];
endmodule

//--- verilog/pixel_output.sv
// --------------------
// Colour expansion with blanking, registered on the pixel strobe
// --------------------
module pixel_output (
	input  logic                    clk_49m,
	input  logic                    reset,
	raster_if.sink                  raster,
	input  blueprint_pkg::spr_pix_t pix_i,
	input  logic                    hsync_i,
	input  logic                    vsync_i,
	input  logic                    csync_i,
	output blueprint_pkg::colour_t  red_o,
	output blueprint_pkg::colour_t  green_o,
	output blueprint_pkg::colour_t  blue_o,
	output logic                    hblank_o,
	output logic                    vblank_o,
	output logic                    hsync_o,
	output logic                    vsync_o,
	output logic                    csync_o
);
	logic blank;

	assign blank = raster.hblank || raster.vblank;

	// Colours and timing share one register stage so they stay aligned
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			red_o    <= '0;
			green_o  <= '0;
			blue_o   <= '0;
			hblank_o <= 1'b0;
			vblank_o <= 1'b0;
			hsync_o  <= 1'b0;
			vsync_o  <= 1'b0;
			csync_o  <= 1'b0;
		end else if (raster.cen) begin
			// Each plane bit is full on or off, empty pixels are black
			red_o    <= (pix_i.r && !blank) ? blueprint_pkg::full_level : '0;
			green_o  <= (pix_i.g && !blank) ? blueprint_pkg::full_level : '0;
			blue_o   <= (pix_i.b && !blank) ? blueprint_pkg::full_level : '0;
			hblank_o <= raster.hblank;
			vblank_o <= raster.vblank;
			hsync_o  <= hsync_i;
			vsync_o  <= vsync_i;
			csync_o  <= csync_i;
		end
	end
endmodule

//--- verilog/sprite_video.sv
// --------------------
// Sprite video path top level
// Raster counter, sprite scanner, line buffer and pixel output
// --------------------
module sprite_video #(
	parameter int cen_num = 89,
	parameter int cen_den = 875
) (
	input  logic                   clk_49m,
	input  logic                   reset,
	input  logic [3:0]             h_center_i,
	input  logic [3:0]             v_center_i,
	// Sprite attribute RAM load
	input  logic                   spr_wr_i,
	input  logic [7:0]             spr_waddr_i,
	input  logic [7:0]             spr_wdata_i,
	// Graphics load, three planes per write
	input  logic                   gfx_wr_i,
	input  logic [11:0]            gfx_waddr_i,
	input  logic [7:0]             gfx_r_i,
	input  logic [7:0]             gfx_b_i,
	input  logic [7:0]             gfx_g_i,
	output blueprint_pkg::colour_t red_o,
	output blueprint_pkg::colour_t green_o,
	output blueprint_pkg::colour_t blue_o,
	output logic                   hsync_o,
	output logic                   vsync_o,
	output logic                   csync_o,
	output logic                   hblank_o,
	output logic                   vblank_o,
	output logic                   ce_pix_o
);
	logic                     cen;
	logic                     hsync;
	logic                     vsync;
	logic                     csync;
	blueprint_pkg::spr_addr_t spr_raddr;
	byte                      spr_rdata;
	blueprint_pkg::gfx_addr_t gfx_raddr;
	blueprint_pkg::gfx_row_t  gfx_rdata;
	blueprint_pkg::gfx_row_t  gfx_wdata;
	blueprint_pkg::spr_pix_t  pix;

	raster_if    raster ();
	sprite_wr_if spr_wr ();

	assign gfx_wdata = '{r: gfx_r_i, b: gfx_b_i, g: gfx_g_i};
	assign ce_pix_o  = cen;

	// --------------------
	// Timing
	pixel_cen #(.cen_num(cen_num), .cen_den(cen_den)) u_cen (
		.clk_49m, .reset, .cen_o(cen)
	);

	video_timing u_timing (
		.clk_49m, .reset, .cen_i(cen), .h_center_i, .v_center_i,
		.raster(raster), .hsync_o(hsync), .vsync_o(vsync), .csync_o(csync)
	);

	// --------------------
	// Memories
	sync_ram #(.payload_t(byte), .addr_w(8)) u_spr_ram (
		.clk_49m, .we_i(spr_wr_i), .waddr_i(spr_waddr_i), .wdata_i(spr_wdata_i),
		.raddr_i(spr_raddr), .rdata_o(spr_rdata)
	);

	sync_ram #(.payload_t(blueprint_pkg::gfx_row_t), .addr_w(12)) u_gfx_ram (
		.clk_49m, .we_i(gfx_wr_i), .waddr_i(gfx_waddr_i), .wdata_i(gfx_wdata),
		.raddr_i(gfx_raddr), .rdata_o(gfx_rdata)
	);

	// --------------------
	// Sprite pipeline
	sprite_scanner u_scanner (
		.clk_49m, .reset, .raster(raster),
		.spr_raddr_o(spr_raddr), .spr_rdata_i(spr_rdata),
		.gfx_raddr_o(gfx_raddr), .gfx_rdata_i(gfx_rdata),
		.wr(spr_wr)
	);

	line_buffer u_linebuf (
		.clk_49m, .reset, .raster(raster), .wr(spr_wr), .pix_o(pix)
	);

	pixel_output u_out (
		.clk_49m, .reset, .raster(raster), .pix_i(pix),
		.hsync_i(hsync), .vsync_i(vsync), .csync_i(csync),
		.red_o, .green_o, .blue_o, .hblank_o, .vblank_o,
		.hsync_o, .vsync_o, .csync_o
	);
endmodule

//--- test/tb_sprite_video.sv
// --------------------
// Testbench for the sprite video path
// Loads sprites from the stimulus file, then checks raster, syncs and pixels
// --------------------
module tb_sprite_video;
	localparam int h_total  = blueprint_pkg::h_total;
	localparam int h_active = blueprint_pkg::h_active;
	localparam int v_total  = blueprint_pkg::v_total;
	localparam int v_first  = blueprint_pkg::v_first;
	localparam int v_last   = blueprint_pkg::v_last;
	localparam int hs_base  = blueprint_pkg::hs_base;
	localparam int vs_base  = blueprint_pkg::vs_base;
	localparam int hs_width = blueprint_pkg::hs_width;
	localparam int vs_width = blueprint_pkg::vs_width;
	localparam int frame_px = h_total * v_total;
	// Two frames at up to 10 clocks per pixel, 8 time units per clock
	localparam int watchdog_t = 2 * frame_px * 10 * 8;

	logic                   clk_49m = 1'b0;
	logic                   reset;
	logic [3:0]             h_center_i;
	logic [3:0]             v_center_i;
	logic                   spr_wr_i;
	logic [7:0]             spr_waddr_i;
	logic [7:0]             spr_wdata_i;
	logic                   gfx_wr_i;
	logic [11:0]            gfx_waddr_i;
	logic [7:0]             gfx_r_i;
	logic [7:0]             gfx_b_i;
	logic [7:0]             gfx_g_i;
	blueprint_pkg::colour_t red_o;
	blueprint_pkg::colour_t green_o;
	blueprint_pkg::colour_t blue_o;
	logic                   hsync_o;
	logic                   vsync_o;
	logic                   csync_o;
	logic                   hblank_o;
	logic                   vblank_o;
	logic                   ce_pix_o;

	int    seed = 18223;
	int    hc;
	int    vc;
	// Raster position shown on the outputs
	int    v;
	int    col;
	string where;
	bit    failed;

	// --------------------
	// Stimulus tables
	logic [15:0]            spr_q [$];
	logic [35:0]            gfx_q [$];
	int                     e_v [$];
	int                     e_col [$];
	blueprint_pkg::colour_t e_r [$];
	blueprint_pkg::colour_t e_g [$];
	blueprint_pkg::colour_t e_b [$];

	always #4 clk_49m = ~clk_49m;

	sprite_video #(.cen_num(89), .cen_den(875)) dut (
		.clk_49m, .reset, .h_center_i, .v_center_i,
		.spr_wr_i, .spr_waddr_i, .spr_wdata_i,
		.gfx_wr_i, .gfx_waddr_i, .gfx_r_i, .gfx_b_i, .gfx_g_i,
		.red_o, .green_o, .blue_o, .hsync_o, .vsync_o, .csync_o,
		.hblank_o, .vblank_o, .ce_pix_o
	);

	// --------------------
	// Error reporting and compares
	task automatic report_error(string msg);
		failed = 1'b1;
		$display("FAILED at %0t: %s", $time, msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic compare_colour(string what, blueprint_pkg::colour_t got,
		blueprint_pkg::colour_t exp);
		if (got !== exp) begin
			report_error($sformatf("%s is %0d, expected %0d %s", what, got, exp, where));
		end
	endtask

	task automatic compare_bit(string what, logic got, logic exp);
		if (got !== exp) begin
			report_error($sformatf("%s is %b, expected %b %s", what, got, exp, where));
		end
	endtask

	task automatic verify_count(string what, int got, int lo, int hi);
		if (got < lo || got > hi) begin
			report_error($sformatf("%s is %0d, outside %0d..%0d %s", what, got, lo, hi, where));
		end
	endtask

	// All colour, sync and blank outputs low
	task automatic outputs_idle();
		compare_colour("red_o", red_o, '0);
		compare_colour("green_o", green_o, '0);
		compare_colour("blue_o", blue_o, '0);
		compare_bit("hsync_o", hsync_o, 1'b0);
		compare_bit("vsync_o", vsync_o, 1'b0);
		compare_bit("csync_o", csync_o, 1'b0);
		compare_bit("hblank_o", hblank_o, 1'b0);
		compare_bit("vblank_o", vblank_o, 1'b0);
	endtask

	// --------------------
	// Stimulus file and memory loading
	task automatic load_stimulus();
		int               fd;
		int               n;
		int               a;
		int               r;
		int               g;
		int               b;
		int               ev;
		int               ec;
		logic [7:0]       kind;
		logic [8*128-1:0] rest;
		fd = $fopen("test/sprite_video_stimulus.txt", "r");
		if (fd == 0) begin
			report_error("cannot open test/sprite_video_stimulus.txt");
		end
		while ($fscanf(fd, " %c", kind) == 1) begin
			case (kind)
				"#": n = $fgets(rest, fd);
				"S": begin
					n = $fscanf(fd, "%h %h", a, r);
					spr_q.push_back({8'(a), 8'(r)});
				end
				"G": begin
					n = $fscanf(fd, "%h %h %h %h", a, r, b, g);
					gfx_q.push_back({12'(a), 8'(r), 8'(b), 8'(g)});
				end
				"E": begin
					n = $fscanf(fd, "%d %d %h %h %h", ev, ec, r, g, b);
					e_v.push_back(ev);
					e_col.push_back(ec);
					e_r.push_back(5'(r));
					e_g.push_back(5'(g));
					e_b.push_back(5'(b));
				end
				default: report_error("unknown line kind in the stimulus file");
			endcase
		end
		$fclose(fd);
	endtask

	task automatic fill_memories();
		// Background sprites keep byte 0 below 16 so they only hit in vblank
		for (int i = 0; i < 256; i++) begin
			@(posedge clk_49m);
			spr_wr_i    <= 1'b1;
			spr_waddr_i <= 8'(i);
			spr_wdata_i <= 8'((i >> 4) ^ (i & 15));
		end
		for (int i = 0; i < spr_q.size(); i++) begin
			@(posedge clk_49m);
			spr_waddr_i <= spr_q[i][15:8];
			spr_wdata_i <= spr_q[i][7:0];
		end
		// Pattern over the whole graphics address
		// Background sprites then draw real pixels during vblank
		for (int i = 0; i < 4096; i++) begin
			@(posedge clk_49m);
			spr_wr_i    <= 1'b0;
			gfx_wr_i    <= 1'b1;
			gfx_waddr_i <= 12'(i);
			gfx_r_i     <= 8'(i);
			gfx_b_i     <= 8'(i >> 4);
			gfx_g_i     <= 8'(i ^ (i >> 4));
		end
		for (int i = 0; i < gfx_q.size(); i++) begin
			@(posedge clk_49m);
			spr_wr_i <= 1'b0;
			gfx_wr_i <= 1'b1;
			{gfx_waddr_i, gfx_r_i, gfx_b_i, gfx_g_i} <= gfx_q[i];
		end
		@(posedge clk_49m);
		spr_wr_i <= 1'b0;
		gfx_wr_i <= 1'b0;
	endtask

	// --------------------
	// Raster checks
	// Outputs are sampled on the falling edge while ce_pix_o is high
	task automatic wait_strobe(output int gap);
		gap = 0;
		do begin
			@(negedge clk_49m);
			gap++;
		end while (ce_pix_o !== 1'b1);
	endtask

	task automatic scan_frame();
		int   gap;
		int   e_ptr;
		int   hb_low;
		int   vis_lines;
		logic hb_exp;
		logic vb_exp;
		logic hs_exp;
		logic vs_exp;
		e_ptr     = 0;
		hb_low    = 0;
		vis_lines = 0;
		// First strobe with vblank_o low shows line 16, column 0
		do begin
			wait_strobe(gap);
		end while (vblank_o !== 1'b1);
		do begin
			wait_strobe(gap);
		end while (vblank_o !== 1'b0);
		v   = v_first;
		col = 0;
		for (int n = 0; n < frame_px; n++) begin
			where  = $sformatf("at line %0d column %0d", v, col);
			hb_exp = col >= h_active;
			vb_exp = v < v_first || v >= v_last;
			// Sync pulses may run past the end of the count
			hs_exp = (col - hs_base - hc + h_total) % h_total < hs_width;
			vs_exp = (v - vs_base - vc + v_total) % v_total < vs_width;
			compare_bit("hblank_o", hblank_o, hb_exp);
			compare_bit("vblank_o", vblank_o, vb_exp);
			compare_bit("hsync_o", hsync_o, hs_exp);
			compare_bit("vsync_o", vsync_o, vs_exp);
			compare_bit("csync_o", csync_o, !(hs_exp ^ vs_exp));
			if (hb_exp || vb_exp) begin
				compare_colour("red_o", red_o, '0);
				compare_colour("green_o", green_o, '0);
				compare_colour("blue_o", blue_o, '0);
			end
			if (e_ptr < e_v.size() && e_v[e_ptr] == v && e_col[e_ptr] == col) begin
				compare_colour("red_o", red_o, e_r[e_ptr]);
				compare_colour("green_o", green_o, e_g[e_ptr]);
				compare_colour("blue_o", blue_o, e_b[e_ptr]);
				e_ptr++;
			end
			// Active pixels per line and visible lines per frame
			if (!hblank_o) begin
				hb_low++;
			end
			if (col == h_total - 1) begin
				verify_count("pixels with hblank_o low", hb_low, h_active, h_active);
				if (!vblank_o) begin
					vis_lines++;
				end
				hb_low = 0;
			end
			col++;
			if (col == h_total) begin
				col = 0;
				v   = (v + 1) % v_total;
			end
			wait_strobe(gap);
			verify_count("clocks between ce_pix strobes", gap, 9, 10);
		end
		where = "at the end of the frame";
		verify_count("lines with vblank_o low", vis_lines, v_last - v_first, v_last - v_first);
		verify_count("expected pixels reached", e_ptr, e_v.size(), e_v.size());
	endtask

	// --------------------
	// Main sequence
	initial begin
		failed      = 1'b0;
		hc          = $random(seed) & 15;
		vc          = $random(seed) & 15;
		reset       <= 1'b0;
		h_center_i  <= 4'(hc);
		v_center_i  <= 4'(vc);
		spr_wr_i    <= 1'b0;
		spr_waddr_i <= '0;
		spr_wdata_i <= '0;
		gfx_wr_i    <= 1'b0;
		gfx_waddr_i <= '0;
		gfx_r_i     <= '0;
		gfx_b_i     <= '0;
		gfx_g_i     <= '0;
		load_stimulus();

		// Reset low for 8 rising edges
		repeat (7) @(posedge clk_49m);
		@(negedge clk_49m);
		where = "in reset";
		outputs_idle();
		@(posedge clk_49m);
		reset <= 1'b1;
		@(negedge clk_49m);
		where = "right after reset";
		outputs_idle();

		// Memories are loaded long before the first visible line
		fill_memories();
		scan_frame();

		if (!failed) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdog_t);
		$display("Timeout at %0t, the raster checks did not complete", $time);
		$display("Test FAILED");
		$fatal(1);
	end
endmodule

//--- test/sprite_video_stimulus.txt
# S addr data = sprite RAM write, G addr r b g = graphics row write, all hex
# E line column red green blue = expected levels, line and column decimal, levels hex
S 00 c7
S 01 10
S 02 00
S 03 14
S 04 c7
S 05 11
S 06 c0
S 07 18
S 08 8b
S 09 12
S 0a 00
S 0b fc
S fe 80
G 10f f0 3c 01
G 110 01 00 f2
G 12f ff 0f 00
E 55 22 00 00 00
E 56 21 00 00 00
E 56 22 1f 00 00
E 56 24 1f 00 1f
E 56 26 1f 00 00
E 56 27 00 1f 00
E 56 28 00 00 00
E 56 29 00 1f 00
E 56 33 00 1f 00
E 56 34 00 00 00
E 72 22 00 00 00
E 116 0 1f 00 00
E 116 5 1f 00 1f
E 116 6 00 00 00
E 116 254 1f 00 00
E 116 255 1f 00 00
E 116 256 00 00 00
E 250 22 00 00 00
E 5 22 00 00 00

//--- compile.f
verilog/blueprint_pkg.sv
verilog/video_if.sv
verilog/pixel_cen.sv
verilog/video_timing.sv
verilog/sync_ram.sv
verilog/sprite_scanner.sv
verilog/line_buffer.sv
verilog/pixel_output.sv
verilog/sprite_video.sv
test/tb_sprite_video.sv

//--- Bender.yml
package:
  name: sprite_video

sources:
  - files:
      - verilog/blueprint_pkg.sv
      - verilog/video_if.sv
      - verilog/pixel_cen.sv
      - verilog/video_timing.sv
      - verilog/sync_ram.sv
      - verilog/sprite_scanner.sv
      - verilog/line_buffer.sv
      - verilog/pixel_output.sv
      - verilog/sprite_video.sv
  - target: test
    files:
      - test/tb_sprite_video.sv
